// ==== build.f ====
rtl/wh_noc_pkg.sv
rtl/cache_dma_pkg.sv
rtl/wh_flit_buffer.sv
rtl/wh_to_cache_dma_fanout.sv
rtl/dma_mem_bank.sv
rtl/dma_subsystem_top.sv
sim/tb_dma_subsystem.sv

// ==== rtl/cache_dma_pkg.sv ====
// Cache DMA definitions
// Field widths of the DMA request packet and the burst shape

`default_nettype none

package cache_dma_pkg;

  // byte address into the endpoint memory
  localparam int dma_addr_width_c = 16;

  // data beats per transfer, one mask bit per beat
  localparam int burst_len_c  = 4;
  localparam int mask_width_c = burst_len_c;

  localparam int dma_pkt_width_c = dma_addr_width_c + mask_width_c + 1;

  typedef struct packed {
    logic                        write_not_read;
    logic [mask_width_c-1:0]     mask;
    logic [dma_addr_width_c-1:0] addr;
  } dma_pkt_s;

endpackage

`default_nettype wire

// ==== rtl/dma_mem_bank.sv ====
// DMA memory endpoint
// Block memory behind a cache DMA port. Streams read bursts out
// over a ready-and channel and stores write bursts under a mask

`default_nettype none

module dma_mem_bank #(
  parameter int mem_words_p = 64
) (
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  cache_dma_pkg::dma_pkt_s             pkt_i,
  input  logic                                pkt_v_i,
  output logic                                pkt_yumi_o,

  input  logic [wh_noc_pkg::flit_width_c-1:0] wdata_i,
  input  logic                                wdata_v_i,
  output logic                                wdata_yumi_o,

  output logic [wh_noc_pkg::flit_width_c-1:0] rdata_o,
  output logic                                rdata_v_o,
  input  logic                                rdata_ready_and_i
);

  import wh_noc_pkg::*;
  import cache_dma_pkg::*;

  localparam int idx_width_lp  = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;
  localparam int beat_width_lp = $clog2(burst_len_c);

  logic [flit_width_c-1:0]     mem_r [mem_words_p];
  logic                        rd_open_r;
  logic                        wr_open_r;
  logic [beat_width_lp-1:0]    beat_r;
  logic [dma_addr_width_c-1:0] base_r;
  logic [mask_width_c-1:0]     mask_r;
  logic [dma_addr_width_c-1:0] beat_addr;
  logic [idx_width_lp-1:0]     word_idx;
  logic                        last_beat;
  logic                        rd_fire;

  // word index of beat 0 is addr/4 rounded down to a burst boundary
  assign beat_addr = base_r + dma_addr_width_c'(beat_r);
  assign word_idx  = idx_width_lp'(beat_addr % mem_words_p);
  assign last_beat = (beat_r == beat_width_lp'(burst_len_c - 1));

  assign pkt_yumi_o   = pkt_v_i & ~rd_open_r & ~wr_open_r;
  assign wdata_yumi_o = wr_open_r & wdata_v_i;
  assign rdata_v_o    = rd_open_r;
  assign rdata_o      = mem_r[word_idx];
  assign rd_fire      = rd_open_r & rdata_ready_and_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_open_r <= 1'b0;
      wr_open_r <= 1'b0;
      beat_r    <= '0;
    end else if (pkt_yumi_o) begin
      rd_open_r <= ~pkt_i.write_not_read;
      wr_open_r <= pkt_i.write_not_read;
      beat_r    <= '0;
    end else if (rd_fire || wdata_yumi_o) begin
      beat_r <= beat_r + 1'b1;
      if (last_beat) begin
        rd_open_r <= 1'b0;
        wr_open_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pkt_yumi_o) begin
      base_r <= {2'b00, pkt_i.addr[dma_addr_width_c-1:4], 2'b00};
      mask_r <= pkt_i.mask;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mem_words_p; i++) begin
        mem_r[i] <= '0;
      end
    end else if (wdata_yumi_o && mask_r[beat_r]) begin
      mem_r[word_idx] <= wdata_i;
    end
  end

  no_mixed_burst_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(rd_open_r && wr_open_r));

endmodule

`default_nettype wire

// ==== rtl/dma_subsystem_top.sv ====
// Wormhole DMA subsystem
// Input flit buffer, fanout converter and a bank of memory endpoints

`default_nettype none

module dma_subsystem_top #(
  parameter  int num_dma_p   = 2,
  parameter  int mem_words_p = 64,
  localparam int id_width_lp = (num_dma_p > 1) ? $clog2(num_dma_p) : 1
) (
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  logic [wh_noc_pkg::flit_width_c-1:0] in_data_i,
  input  logic                                in_v_i,
  output logic                                in_ready_and_o,
  input  logic [id_width_lp-1:0]              wh_dma_id_i,

  output logic [wh_noc_pkg::flit_width_c-1:0] out_data_o,
  output logic                                out_v_o,
  input  logic                                out_ready_and_i
);

  import wh_noc_pkg::*;
  import cache_dma_pkg::*;

  logic [flit_width_c-1:0]    buf_data;
  logic                       buf_v;
  logic                       buf_yumi;

  logic [dma_pkt_width_c-1:0] dma_pkt;
  logic [num_dma_p-1:0]       dma_pkt_v;
  logic [num_dma_p-1:0]       dma_pkt_yumi;

  logic [num_dma_p-1:0][flit_width_c-1:0] dma_wdata;
  logic [num_dma_p-1:0]       dma_wdata_v;
  logic [num_dma_p-1:0]       dma_wdata_yumi;

  logic [num_dma_p-1:0][flit_width_c-1:0] dma_rdata;
  logic [num_dma_p-1:0]       dma_rdata_v;
  logic [num_dma_p-1:0]       dma_rdata_ready_and;

  wh_flit_buffer i_buf (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .data_i      (in_data_i),
    .v_i         (in_v_i),
    .ready_and_o (in_ready_and_o),
    .data_o      (buf_data),
    .v_o         (buf_v),
    .yumi_i      (buf_yumi)
  );

  wh_to_cache_dma_fanout #(
    .num_dma_p (num_dma_p)
  ) i_fanout (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .link_data_i           (buf_data),
    .link_v_i              (buf_v),
    .link_yumi_o           (buf_yumi),
    .dma_id_i              (wh_dma_id_i),
    .out_data_o            (out_data_o),
    .out_v_o               (out_v_o),
    .out_ready_and_i       (out_ready_and_i),
    .dma_pkt_o             (dma_pkt),
    .dma_pkt_v_o           (dma_pkt_v),
    .dma_pkt_yumi_i        (dma_pkt_yumi),
    .dma_wdata_o           (dma_wdata),
    .dma_wdata_v_o         (dma_wdata_v),
    .dma_wdata_yumi_i      (dma_wdata_yumi),
    .dma_rdata_i           (dma_rdata),
    .dma_rdata_v_i         (dma_rdata_v),
    .dma_rdata_ready_and_o (dma_rdata_ready_and)
  );

  // one endpoint per DMA id, all see the same packet bus
  for (genvar k = 0; k < num_dma_p; k++) begin : g_bank
    dma_mem_bank #(
      .mem_words_p (mem_words_p)
    ) i_bank (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .pkt_i             (dma_pkt),
      .pkt_v_i           (dma_pkt_v[k]),
      .pkt_yumi_o        (dma_pkt_yumi[k]),
      .wdata_i           (dma_wdata[k]),
      .wdata_v_i         (dma_wdata_v[k]),
      .wdata_yumi_o      (dma_wdata_yumi[k]),
      .rdata_o           (dma_rdata[k]),
      .rdata_v_o         (dma_rdata_v[k]),
      .rdata_ready_and_i (dma_rdata_ready_and[k])
    );
  end

endmodule

`default_nettype wire

// ==== rtl/wh_flit_buffer.sv ====
// Wormhole flit buffer
// Two-entry queue between the ready-and input link and the
// valid-then-yumi side of the DMA converter

`default_nettype none

module wh_flit_buffer (
  input  logic                             clk_i,
  input  logic                             reset_i,

  input  logic [wh_noc_pkg::flit_width_c-1:0] data_i,
  input  logic                             v_i,
  output logic                             ready_and_o,

  output logic [wh_noc_pkg::flit_width_c-1:0] data_o,
  output logic                             v_o,
  input  logic                             yumi_i
);

  import wh_noc_pkg::*;

  logic [flit_width_c-1:0] slot_r [2];
  logic                    wptr_r;
  logic                    rptr_r;
  logic [1:0]              count_r;
  logic                    enq;

  assign ready_and_o = (count_r != 2'd2);
  assign enq         = v_i & ready_and_o;

  assign v_o    = (count_r != 2'd0);
  assign data_o = slot_r[rptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      count_r <= 2'd0;
    end else begin
      if (enq) begin
        wptr_r <= ~wptr_r;
      end
      if (yumi_i) begin
        rptr_r <= ~rptr_r;
      end
      case ({enq, yumi_i})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      slot_r[wptr_r] <= data_i;
    end
  end

  // the converter may only pop a flit that is already on display
  yumi_needs_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

// ==== rtl/wh_noc_pkg.sv ====
// Wormhole network definitions
// Flit and header field widths, the header flit layout and the
// opcodes carried by cache DMA wormhole packets

`default_nettype none

package wh_noc_pkg;

  localparam int flit_width_c = 32;
  localparam int cord_width_c = 4;
  localparam int len_width_c  = 4;
  localparam int cid_width_c  = 2;

  typedef enum logic [1:0] {
    e_wh_read             = 2'd0,
    e_wh_write_non_masked = 2'd1,
    e_wh_write_masked     = 2'd2
  } wh_opcode_e;

  // fields listed from the top bit down, cord sits at bit 0
  typedef struct packed {
    logic [flit_width_c-2*cord_width_c-2*cid_width_c-len_width_c-3:0] unused;
    logic [cid_width_c-1:0]  src_cid;
    logic [cord_width_c-1:0] src_cord;
    wh_opcode_e              opcode;
    logic [cid_width_c-1:0]  cid;
    logic [len_width_c-1:0]  len;
    logic [cord_width_c-1:0] cord;
  } header_flit_s;

endpackage

`default_nettype wire

// ==== rtl/wh_to_cache_dma_fanout.sv ====
// Wormhole to cache DMA fanout
// Send side turns header, address, optional mask and write data flits
// into DMA requests for the endpoint picked by dma_id_i.
// Receive side arbitrates fill data round-robin and returns it as a
// wormhole packet addressed from the per-endpoint source table

`default_nettype none

module wh_to_cache_dma_fanout #(
  parameter  int num_dma_p   = 2,
  localparam int id_width_lp = (num_dma_p > 1) ? $clog2(num_dma_p) : 1
) (
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  logic [wh_noc_pkg::flit_width_c-1:0] link_data_i,
  input  logic                                link_v_i,
  output logic                                link_yumi_o,
  input  logic [id_width_lp-1:0]              dma_id_i,

  output logic [wh_noc_pkg::flit_width_c-1:0] out_data_o,
  output logic                                out_v_o,
  input  logic                                out_ready_and_i,

  output cache_dma_pkg::dma_pkt_s             dma_pkt_o,
  output logic [num_dma_p-1:0]                dma_pkt_v_o,
  input  logic [num_dma_p-1:0]                dma_pkt_yumi_i,

  output logic [num_dma_p-1:0][wh_noc_pkg::flit_width_c-1:0] dma_wdata_o,
  output logic [num_dma_p-1:0]                dma_wdata_v_o,
  input  logic [num_dma_p-1:0]                dma_wdata_yumi_i,

  input  logic [num_dma_p-1:0][wh_noc_pkg::flit_width_c-1:0] dma_rdata_i,
  input  logic [num_dma_p-1:0]                dma_rdata_v_i,
  output logic [num_dma_p-1:0]                dma_rdata_ready_and_o
);

  import wh_noc_pkg::*;
  import cache_dma_pkg::*;

  localparam int count_width_lp = $clog2(burst_len_c);
  localparam logic [count_width_lp-1:0] last_beat_lp = count_width_lp'(burst_len_c - 1);

  header_flit_s hdr_in;
  header_flit_s hdr_out;

  assign hdr_in = link_data_i;

  // reply coordinate and cid per endpoint
  logic [cord_width_c-1:0] src_cord_r [num_dma_p];
  logic [cid_width_c-1:0]  src_cid_r  [num_dma_p];
  logic                    table_we;

  typedef enum logic [2:0] {
    SEND_RESET,
    SEND_READY,
    SEND_ADDR,
    SEND_MASK,
    SEND_DATA
  } send_state_e;

  send_state_e               send_state_r, send_state_n;
  wh_opcode_e                opcode_r, opcode_n;
  logic [id_width_lp-1:0]    send_id_r, send_id_n;
  logic [dma_addr_width_c-1:0] addr_r, addr_n;
  logic [count_width_lp-1:0] send_count_r, send_count_n;

  always_comb begin
    send_state_n  = send_state_r;
    opcode_n      = opcode_r;
    send_id_n     = send_id_r;
    addr_n        = addr_r;
    send_count_n  = send_count_r;
    table_we      = 1'b0;
    link_yumi_o   = 1'b0;
    dma_pkt_o     = '0;
    dma_pkt_v_o   = '0;
    dma_wdata_o   = '0;
    dma_wdata_v_o = '0;

    case (send_state_r)
      SEND_RESET: begin
        send_state_n = SEND_READY;
      end

      // header: remember opcode, target and where to reply
      SEND_READY: begin
        if (link_v_i) begin
          link_yumi_o  = 1'b1;
          table_we     = 1'b1;
          opcode_n     = hdr_in.opcode;
          send_id_n    = dma_id_i;
          send_state_n = SEND_ADDR;
        end
      end

      SEND_ADDR: begin
        dma_pkt_o.write_not_read = (opcode_r != e_wh_read);
        dma_pkt_o.addr           = dma_addr_width_c'(link_data_i);
        dma_pkt_o.mask           = '1;
        if (opcode_r == e_wh_write_masked) begin
          // hold the address until the mask flit shows up
          if (link_v_i) begin
            link_yumi_o  = 1'b1;
            addr_n       = dma_addr_width_c'(link_data_i);
            send_state_n = SEND_MASK;
          end
        end else begin
          dma_pkt_v_o[send_id_r] = link_v_i;
          if (dma_pkt_yumi_i[send_id_r]) begin
            link_yumi_o  = 1'b1;
            send_state_n = (opcode_r == e_wh_read) ? SEND_READY : SEND_DATA;
          end
        end
      end

      SEND_MASK: begin
        dma_pkt_o.write_not_read = 1'b1;
        dma_pkt_o.addr           = addr_r;
        dma_pkt_o.mask           = mask_width_c'(link_data_i);
        dma_pkt_v_o[send_id_r]   = link_v_i;
        if (dma_pkt_yumi_i[send_id_r]) begin
          link_yumi_o  = 1'b1;
          send_state_n = SEND_DATA;
        end
      end

      SEND_DATA: begin
        dma_wdata_o[send_id_r]   = link_data_i;
        dma_wdata_v_o[send_id_r] = link_v_i;
        if (dma_wdata_yumi_i[send_id_r]) begin
          link_yumi_o = 1'b1;
          if (send_count_r == last_beat_lp) begin
            send_count_n = '0;
            send_state_n = SEND_READY;
          end else begin
            send_count_n = send_count_r + 1'b1;
          end
        end
      end

      default: begin
        send_state_n = SEND_READY;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    addr_r <= addr_n;
    if (table_we) begin
      src_cord_r[dma_id_i] <= hdr_in.src_cord;
      src_cid_r[dma_id_i]  <= hdr_in.src_cid;
    end
  end

  // receive side, recv_id_r doubles as the last round-robin winner
  typedef enum logic [1:0] {
    RECV_RESET,
    RECV_READY,
    RECV_HEADER,
    RECV_DATA
  } recv_state_e;

  recv_state_e               recv_state_r, recv_state_n;
  logic [id_width_lp-1:0]    recv_id_r, recv_id_n;
  logic [count_width_lp-1:0] recv_count_r, recv_count_n;
  logic                      rr_found;
  logic [id_width_lp-1:0]    rr_pick;

  // search starts one past the previous winner
  always_comb begin
    int idx;
    rr_found = 1'b0;
    rr_pick  = recv_id_r;
    for (int i = 1; i <= num_dma_p; i++) begin
      idx = (int'(recv_id_r) + i) % num_dma_p;
      if (!rr_found && dma_rdata_v_i[idx]) begin
        rr_found = 1'b1;
        rr_pick  = id_width_lp'(idx);
      end
    end
  end

  always_comb begin
    recv_state_n          = recv_state_r;
    recv_id_n             = recv_id_r;
    recv_count_n          = recv_count_r;
    out_v_o               = 1'b0;
    out_data_o            = '0;
    dma_rdata_ready_and_o = '0;

    hdr_out        = '0;
    hdr_out.cord   = src_cord_r[recv_id_r];
    hdr_out.cid    = src_cid_r[recv_id_r];
    hdr_out.len    = len_width_c'(burst_len_c);
    hdr_out.opcode = e_wh_read;

    case (recv_state_r)
      RECV_RESET: begin
        recv_state_n = RECV_READY;
      end

      RECV_READY: begin
        if (rr_found) begin
          recv_id_n    = rr_pick;
          recv_state_n = RECV_HEADER;
        end
      end

      RECV_HEADER: begin
        out_v_o    = 1'b1;
        out_data_o = hdr_out;
        if (out_ready_and_i) begin
          recv_state_n = RECV_DATA;
        end
      end

      RECV_DATA: begin
        out_v_o    = dma_rdata_v_i[recv_id_r];
        out_data_o = dma_rdata_i[recv_id_r];
        dma_rdata_ready_and_o[recv_id_r] = out_ready_and_i;
        if (dma_rdata_v_i[recv_id_r] && out_ready_and_i) begin
          if (recv_count_r == last_beat_lp) begin
            recv_count_n = '0;
            recv_state_n = RECV_READY;
          end else begin
            recv_count_n = recv_count_r + 1'b1;
          end
        end
      end

      default: begin
        recv_state_n = RECV_READY;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= SEND_RESET;
      opcode_r     <= e_wh_read;
      send_id_r    <= '0;
      send_count_r <= '0;
      recv_state_r <= RECV_RESET;
      recv_id_r    <= '0;
      recv_count_r <= '0;
    end else begin
      send_state_r <= send_state_n;
      opcode_r     <= opcode_n;
      send_id_r    <= send_id_n;
      send_count_r <= send_count_n;
      recv_state_r <= recv_state_n;
      recv_id_r    <= recv_id_n;
      recv_count_r <= recv_count_n;
    end
  end

  // a request never goes to two endpoints at once
  one_pkt_v_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(dma_pkt_v_o));

  // side input must name an existing endpoint when the header is taken
  dma_id_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (send_state_r == SEND_READY && link_v_i) |-> (int'(dma_id_i) < num_dma_p));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the DMA subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_subsystem -f build.f \
  || { echo "verilator build failed"; exit 1; }
result=$(./obj_dir/Vtb_dma_subsystem)
echo "$result"
echo "$result" | grep -qF '*** PASSED ***' && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sim/dma_trace.txt ====
// columns: endpoint opcode src_cord src_cid address mask data0 data1 data2 data3
// opcode 0 read, 1 write, 2 masked write; every value is hex
0 1 3 1 0040 f 11111111 22222222 33333333 44444444
0 0 3 1 0040 0 00000000 00000000 00000000 00000000
1 1 5 2 0080 f a0000001 a0000002 a0000003 a0000004
1 2 5 2 0080 5 b0000001 b0000002 b0000003 b0000004
1 0 6 3 0080 0 00000000 00000000 00000000 00000000
0 1 3 1 0020 f c0000001 c0000002 c0000003 c0000004
1 1 6 3 0020 f d0000001 d0000002 d0000003 d0000004
0 0 9 0 0020 0 00000000 00000000 00000000 00000000
1 0 a 2 0020 0 00000000 00000000 00000000 00000000
0 0 9 0 0040 0 00000000 00000000 00000000 00000000
1 0 a 2 0080 0 00000000 00000000 00000000 00000000
0 1 9 0 0104 f e0000001 e0000002 e0000003 e0000004
0 0 9 0 0000 0 00000000 00000000 00000000 00000000
0 2 9 0 0000 a f0000001 f0000002 f0000003 f0000004
1 0 a 2 0020 0 00000000 00000000 00000000 00000000
0 0 2 3 0000 0 00000000 00000000 00000000 00000000
1 1 a 2 00f0 f 5a5a0001 5a5a0002 5a5a0003 5a5a0004
1 0 1 1 00f0 0 00000000 00000000 00000000 00000000
0 0 2 3 0030 0 00000000 00000000 00000000 00000000
1 0 1 1 00fc 0 00000000 00000000 00000000 00000000

// ==== sim/tb_dma_subsystem.sv ====
// Testbench for the wormhole DMA subsystem
// Replays a packet trace into the input link and keeps a model of every
// endpoint memory. Each read response on the return link is checked
// against that model while the return link is throttled at random

`default_nettype none

module tb_dma_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  import wh_noc_pkg::*;
  import cache_dma_pkg::*;

  localparam int num_dma_c        = 2;
  localparam int mem_words_c      = 64;
  localparam int id_width_c       = $clog2(num_dma_c);
  localparam int num_pkts_c       = 20;
  localparam int trace_cols_c     = 10;
  localparam int cycles_per_pkt_c = 60;

  logic                    clk_i;
  logic                    reset_i;
  logic [flit_width_c-1:0] in_data_i;
  logic                    in_v_i;
  logic                    in_ready_and_o;
  logic [id_width_c-1:0]   wh_dma_id_i;
  logic [flit_width_c-1:0] out_data_o;
  logic                    out_v_o;
  logic                    out_ready_and_i;

  // one row per packet with endpoint, opcode, src_cord, src_cid, address, mask and four data words
  logic [31:0]             trace_mem [num_pkts_c*trace_cols_c];
  logic [flit_width_c-1:0] model_mem [num_dma_c][mem_words_c];
  logic [flit_width_c-1:0] exp_q [$];
  int                      read_pkt_q [$];

  integer seed = 44808;
  int     pass_count   = 0;
  int     fail_count   = 0;
  int     stray_errors = 0;
  int     resp_errors  = 0;
  int     out_beat     = 0;
  int     reads_done   = 0;
  int     num_reads    = 0;
  logic   trace_loaded = 1'b0;
  logic   monitor_on   = 1'b0;

  dma_subsystem_top #(
    .num_dma_p   (num_dma_c),
    .mem_words_p (mem_words_c)
  ) i_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .in_data_i       (in_data_i),
    .in_v_i          (in_v_i),
    .in_ready_and_o  (in_ready_and_o),
    .wh_dma_id_i     (wh_dma_id_i),
    .out_data_o      (out_data_o),
    .out_v_o         (out_v_o),
    .out_ready_and_i (out_ready_and_i)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] trace_word(input int pkt, input int col);
    return trace_mem[pkt*trace_cols_c + col];
  endfunction

  // byte address over 4 is aligned down to a burst boundary before the beat is added
  function automatic int word_index(input logic [dma_addr_width_c-1:0] addr, input int beat);
    int base;
    base = ((int'(addr) / 4) / burst_len_c) * burst_len_c;
    return (base + beat) % mem_words_c;
  endfunction

  task automatic build_expected();
    header_flit_s                hdr;
    int                          ep;
    logic [1:0]                  op;
    logic [dma_addr_width_c-1:0] addr;
    logic [mask_width_c-1:0]     mask;
    for (int e = 0; e < num_dma_c; e++) begin
      for (int w = 0; w < mem_words_c; w++) begin
        model_mem[e][w] = '0;
      end
    end
    for (int p = 0; p < num_pkts_c; p++) begin
      ep   = int'(trace_word(p, 0));
      op   = 2'(trace_word(p, 1));
      addr = dma_addr_width_c'(trace_word(p, 4));
      if (ep >= num_dma_c || trace_word(p, 1) > 32'd2) begin
        $display("trace packet %0d names a bad endpoint or opcode", p);
        stray_errors++;
      end else if (op == e_wh_read) begin
        hdr        = '0;
        hdr.cord   = cord_width_c'(trace_word(p, 2));
        hdr.cid    = cid_width_c'(trace_word(p, 3));
        hdr.len    = len_width_c'(burst_len_c);
        hdr.opcode = e_wh_read;
        exp_q.push_back(hdr);
        for (int b = 0; b < burst_len_c; b++) begin
          exp_q.push_back(model_mem[ep][word_index(addr, b)]);
        end
        read_pkt_q.push_back(p);
      end else begin
        mask = (op == e_wh_write_masked) ? mask_width_c'(trace_word(p, 5)) : '1;
        for (int b = 0; b < burst_len_c; b++) begin
          if (mask[b]) begin
            model_mem[ep][word_index(addr, b)] = trace_word(p, 6 + b);
          end
        end
      end
    end
    num_reads = read_pkt_q.size();
  endtask

  // starts on a falling edge and returns on the falling edge after the flit moved
  task automatic send_flit(input logic [flit_width_c-1:0] flit);
    logic taken;
    in_data_i = flit;
    in_v_i    = 1'b1;
    taken     = 1'b0;
    while (!taken) begin
      taken = in_ready_and_o;
      @(negedge clk_i);
    end
  endtask

  task automatic drive_packet(input int p);
    header_flit_s hdr;
    logic [1:0]   op;
    op         = 2'(trace_word(p, 1));
    hdr        = '0;
    hdr.cord   = cord_width_c'(trace_word(p, 0));
    hdr.len    = (op == e_wh_read) ? 4'd1 : (op == e_wh_write_masked) ? 4'd6 : 4'd5;
    hdr.opcode = wh_opcode_e'(op);
    hdr.src_cord = cord_width_c'(trace_word(p, 2));
    hdr.src_cid  = cid_width_c'(trace_word(p, 3));
    // endpoint select stays put for the whole packet
    wh_dma_id_i = id_width_c'(trace_word(p, 0));
    send_flit(hdr);
    send_flit(trace_word(p, 4));
    if (op == e_wh_write_masked) begin
      send_flit(trace_word(p, 5));
    end
    if (op != e_wh_read) begin
      for (int b = 0; b < burst_len_c; b++) begin
        send_flit(trace_word(p, 6 + b));
      end
      $display("packet %0d write to endpoint %0d: PASS", p, trace_word(p, 0));
      pass_count++;
    end
  endtask

  task automatic check_reset_state();
    int errs;
    errs = 0;
    assert (out_v_o === 1'b0) else begin
      $display("** Error: out_v_o = %0h after reset, expected 0", out_v_o);
      errs++;
    end
    assert (in_ready_and_o === 1'b1) else begin
      $display("** Error: in_ready_and_o = %0h after reset, expected 1", in_ready_and_o);
      errs++;
    end
    if (errs == 0) begin
      $display("reset state: PASS");
      pass_count++;
    end else begin
      $display("reset state: FAIL");
      fail_count++;
    end
  endtask

  task automatic report_read(input int p);
    if (resp_errors == 0) begin
      $display("packet %0d read from endpoint %0d: PASS", p, trace_word(p, 0));
      pass_count++;
    end else begin
      $display("packet %0d read from endpoint %0d: FAIL", p, trace_word(p, 0));
      fail_count++;
    end
    resp_errors = 0;
    reads_done++;
  endtask

  task automatic take_out_flit(input logic [flit_width_c-1:0] flit);
    logic [flit_width_c-1:0] want;
    if (exp_q.size() == 0) begin
      $display("return link sent flit %08h while no response was expected", flit);
      stray_errors++;
    end else begin
      want = exp_q.pop_front();
      assert (flit === want) else begin
        $display("** Error: out_data_o = %08h, expected %08h in beat %0d", flit, want, out_beat);
        resp_errors++;
      end
      if (out_beat == burst_len_c) begin
        out_beat = 0;
        report_read(read_pkt_q.pop_front());
      end else begin
        out_beat++;
      end
    end
  endtask

  task automatic watch_out_link();
    // once a header has gone out, the data beats follow without a gap in valid
    if (out_beat != 0) begin
      assert (out_v_o === 1'b1) else begin
        $display("return link dropped valid in the middle of a response");
        resp_errors++;
      end
    end
    if (out_v_o && out_ready_and_i) begin
      take_out_flit(out_data_o);
    end
  endtask

  // return link ready is throttled at random
  initial begin
    out_ready_and_i = 1'b0;
    wait (monitor_on);
    forever begin
      @(negedge clk_i);
      out_ready_and_i = (($random(seed) & 32'h3) != 0);
      watch_out_link();
    end
  end

  initial begin
    wait (trace_loaded);
    repeat (num_pkts_c * cycles_per_pkt_c) @(posedge clk_i);
    $display("watchdog expired with %0d of %0d responses finished", reads_done, num_reads);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    in_data_i   = '0;
    in_v_i      = 1'b0;
    wh_dma_id_i = '0;
    $readmemh("sim/dma_trace.txt", trace_mem);
    build_expected();
    trace_loaded = 1'b1;

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    check_reset_state();
    monitor_on = 1'b1;

    for (int p = 0; p < num_pkts_c; p++) begin
      drive_packet(p);
    end
    in_v_i = 1'b0;

    wait (reads_done == num_reads);
    repeat (10) @(negedge clk_i);
    // nothing may be left in flight once every response is in
    assert (out_v_o === 1'b0) else begin
      $display("** Error: out_v_o = %0h after the last response, expected 0", out_v_o);
      stray_errors++;
    end
    assert (in_ready_and_o === 1'b1) else begin
      $display("** Error: in_ready_and_o = %0h after the last packet, expected 1",
               in_ready_and_o);
      stray_errors++;
    end

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && stray_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
